/* list.f */
hdl/mm_types_pkg.sv
hdl/mm_ctrl_pkg.sv
hdl/mac_pe.sv
hdl/mm_lane.sv
hdl/mm_sequencer.sv
hdl/dmme_top.sv
tests/dmme_assertions.sv
tests/dmme_tb.sv

/* tests/dmme_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dmme_tb import mm_types_pkg::*; ();

    localparam int DONE_TIMEOUT = 20;
    localparam int IDLE_TIMEOUT = 20;
    localparam int RANDOM_JOBS  = 12;

    logic     clk;
    logic     rst;
    logic     start;
    operand_t a1;
    operand_t a2;
    operand_t b1;
    operand_t b2;
    logic     busy;
    logic     row1_valid;
    logic     row2_valid;
    logic     done;
    result_t  row1;
    result_t  row2;

    logic [31:0] rng_state;
    result_t     exp_row1;
    result_t     exp_row2;
    int          value_errors;
    int          jobs_started;
    int          done_count;

    dmme_top UUT (
        .clk(clk), .rst(rst), .start(start),
        .a1(a1), .a2(a2), .b1(b1), .b2(b2),
        .busy(busy), .row1_valid(row1_valid), .row2_valid(row2_valid), .done(done),
        .row1(row1), .row2(row2)
    );

    always #2 clk = ~clk;

    // ==================================================
    // Reference model
    // ==================================================
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic operand_t rand_operand();
        operand_t op;
        rng_state = xorshift(rng_state);
        op[31:0] = rng_state;
        rng_state = xorshift(rng_state);
        op[63:32] = rng_state;
        return op;
    endfunction

    function automatic acc_t vec_dot(input vec_t a, input vec_t b);
        acc_t sum;
        sum = 0;
        for (int i = 0; i < VEC_LEN; i++) begin
            sum += acc_t'(a[ELEM_W*i +: ELEM_W]) * acc_t'(b[ELEM_W*i +: ELEM_W]);
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input acc_t expected, input acc_t actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Results are checked while their valid pulse is high.
    always @(negedge clk) begin
        if (rst) begin
            for (int l = 0; l < LANES; l++) begin
                if (row1_valid) begin
                    check_value($sformatf("row1.lane[%0d]", l), exp_row1.lane[l], row1.lane[l]);
                end
                if (row2_valid) begin
                    check_value($sformatf("row2.lane[%0d]", l), exp_row2.lane[l], row2.lane[l]);
                end
            end
            if (done) begin
                done_count++;
            end
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================
    task automatic wait_for_idle();
        int cycles;
        cycles = 0;
        while (busy && cycles < IDLE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            $display("Timeout: busy did not fall within %0d cycles", IDLE_TIMEOUT);
            $display("Testbench failed");
            $finish;
        end
    endtask

    // Cycle stray_at carries a stray start with new operands and 0 means none.
    task automatic wait_for_done(input int stray_at);
        int   cycles;
        logic seen;
        cycles = 1;
        seen = 1'b0;
        while (!seen && cycles <= DONE_TIMEOUT) begin
            if (cycles == stray_at) begin
                a1 = rand_operand();
                a2 = rand_operand();
                b1 = rand_operand();
                b2 = rand_operand();
                start = 1'b1;
            end
            seen = done;
            @(negedge clk);
            start = 1'b0;
            cycles++;
        end
        if (!seen) begin
            $display("Timeout: done did not arrive within %0d cycles", DONE_TIMEOUT);
            $display("Testbench failed");
            $finish;
        end
    endtask

    task automatic run_job(input operand_t a1_v, input operand_t a2_v,
                           input operand_t b1_v, input operand_t b2_v,
                           input int stray_at);
        wait_for_idle();
        a1 = a1_v;
        a2 = a2_v;
        b1 = b1_v;
        b2 = b2_v;
        for (int l = 0; l < LANES; l++) begin
            exp_row1.lane[l] = vec_dot(a1_v.lane[l], b1_v.lane[l])
                             + vec_dot(a2_v.lane[l], b1_v.lane[l]);
            exp_row2.lane[l] = vec_dot(a1_v.lane[l], b2_v.lane[l])
                             + vec_dot(a2_v.lane[l], b2_v.lane[l]);
        end
        jobs_started++;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_for_done(stray_at);
    endtask

    initial begin
        int protocol_errors;
        clk = 1'b0;
        rst = 1'b0;
        start = 1'b0;
        a1 = '0;
        a2 = '0;
        b1 = '0;
        b2 = '0;
        rng_state = 32'h6093efd9;
        exp_row1 = '0;
        exp_row2 = '0;
        value_errors = 0;
        jobs_started = 0;
        done_count = 0;

        repeat (2) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);

        // Idle outputs out of reset.
        check_value("busy", 0, busy);
        check_value("row1_valid", 0, row1_valid);
        check_value("row2_valid", 0, row2_valid);
        check_value("done", 0, done);
        for (int l = 0; l < LANES; l++) begin
            check_value($sformatf("row1.lane[%0d]", l), 0, row1.lane[l]);
            check_value($sformatf("row2.lane[%0d]", l), 0, row2.lane[l]);
        end

        // Corner cases with all-zero and all-FF operands.
        run_job('0, '0, '0, '0, 0);
        run_job('1, '1, '1, '1, 0);
        run_job('1, '0, '1, '1, 0);
        for (int i = 0; i < RANDOM_JOBS; i++) begin
            run_job(rand_operand(), rand_operand(), rand_operand(), rand_operand(), 0);
        end

        // One start while busy goes out before the operands are used, one on the done cycle.
        run_job(rand_operand(), rand_operand(), rand_operand(), rand_operand(), 1);
        repeat (3) @(negedge clk);
        run_job(rand_operand(), rand_operand(), rand_operand(), rand_operand(), 5);
        repeat (3) @(negedge clk);
        run_job(rand_operand(), rand_operand(), rand_operand(), rand_operand(), 0);
        repeat (4) @(negedge clk);

        check_value("done_count", jobs_started, done_count);
        protocol_errors = UUT.u_asrt.error_count;
        $display("Jobs: %0d, value errors: %0d, protocol errors: %0d",
                 jobs_started, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/dmme_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module dmme_assertions import mm_types_pkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    start,
    input logic    busy,
    input logic    row1_valid,
    input logic    row2_valid,
    input logic    done,
    input result_t row1,
    input result_t row2
);

    int   error_count;
    logic accept;

    initial error_count = 0;

    assign accept = start && !busy;

    // ==================================================
    // Pulse timing after an accepted start.
    // ==================================================
    a_row1_pulse: assert property (@(posedge clk) disable iff (!rst)
        accept |=> !row1_valid ##1 !row1_valid ##1 !row1_valid ##1 row1_valid ##1 !row1_valid)
    else begin
        error_count++;
        $error("row1_valid did not pulse once, three cycles after an accepted start");
    end

    a_row2_pulse: assert property (@(posedge clk) disable iff (!rst)
        accept |=> !row2_valid ##1 !row2_valid ##1 !row2_valid ##1 !row2_valid
            ##1 (row2_valid && done) ##1 !row2_valid)
    else begin
        error_count++;
        $error("row2_valid and done did not pulse once, four cycles after an accepted start");
    end

    a_busy_hold: assert property (@(posedge clk) disable iff (!rst)
        accept |=> busy ##1 busy ##1 busy ##1 busy ##1 busy ##1 !busy)
    else begin
        error_count++;
        $error("busy did not stay high for the whole job");
    end

    // A valid pulse needs an accepted start behind it.
    a_row1_has_job: assert property (@(posedge clk) disable iff (!rst)
        row1_valid |-> $past(accept, 4))
    else begin
        error_count++;
        $error("row1_valid pulsed without an accepted start");
    end

    a_done_has_job: assert property (@(posedge clk) disable iff (!rst)
        done |-> $past(accept, 5))
    else begin
        error_count++;
        $error("done pulsed without an accepted start");
    end

    // Results hold between capture pulses.
    a_row1_stable: assert property (@(posedge clk) disable iff (!rst)
        !$stable(row1) |-> row1_valid)
    else begin
        error_count++;
        $error("row1 changed outside its valid pulse");
    end

    a_row2_stable: assert property (@(posedge clk) disable iff (!rst)
        !$stable(row2) |-> row2_valid)
    else begin
        error_count++;
        $error("row2 changed outside its valid pulse");
    end

endmodule

bind dmme_top dmme_assertions u_asrt (
    .clk(clk), .rst(rst), .start(start), .busy(busy),
    .row1_valid(row1_valid), .row2_valid(row2_valid), .done(done),
    .row1(row1), .row2(row2)
);

`default_nettype wire

/* hdl/dmme_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dmme_top import mm_types_pkg::*; import mm_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  operand_t a1,
    input  operand_t a2,
    input  operand_t b1,
    input  operand_t b2,
    output logic     busy,
    output logic     row1_valid,
    output logic     row2_valid,
    output logic     done,
    output result_t  row1,
    output result_t  row2
);

    logic   load;
    logic   cap_row1;
    logic   cap_row2;
    pe_en_t pe_en;
    acc_t   row1_l0;
    acc_t   row1_l1;
    acc_t   row2_l0;
    acc_t   row2_l1;

    mm_sequencer u_seq (
        .clk(clk), .rst(rst), .start(start),
        .busy(busy), .load(load), .pe_en(pe_en),
        .cap_row1(cap_row1), .cap_row2(cap_row2),
        .row1_valid(row1_valid), .row2_valid(row2_valid), .done(done)
    );

    // Both lanes share the schedule.
    mm_lane lane0 (
        .clk(clk), .rst(rst), .load(load),
        .a1(a1.lane[0]), .a2(a2.lane[0]), .b1(b1.lane[0]), .b2(b2.lane[0]),
        .pe_en(pe_en), .cap_row1(cap_row1), .cap_row2(cap_row2),
        .row1(row1_l0), .row2(row2_l0)
    );

    mm_lane lane1 (
        .clk(clk), .rst(rst), .load(load),
        .a1(a1.lane[1]), .a2(a2.lane[1]), .b1(b1.lane[1]), .b2(b2.lane[1]),
        .pe_en(pe_en), .cap_row1(cap_row1), .cap_row2(cap_row2),
        .row1(row1_l1), .row2(row2_l1)
    );

    assign row1 = {row1_l1, row1_l0};
    assign row2 = {row2_l1, row2_l0};

endmodule

`default_nettype wire

/* hdl/mm_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module mm_sequencer import mm_ctrl_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    output logic   busy,
    output logic   load,
    output pe_en_t pe_en,
    output logic   cap_row1,
    output logic   cap_row2,
    output logic   row1_valid,
    output logic   row2_valid,
    output logic   done
);

    seq_state_t state;
    seq_state_t next_state;
    logic [STEP_W-1:0] step;

    assign load = start && (state == SEQ_IDLE);
    assign busy = (state != SEQ_IDLE);

    // ==================================================
    // FSM
    // ==================================================
    always_comb begin
        next_state = state;
        case (state)
            SEQ_IDLE: begin
                if (start) begin
                    next_state = SEQ_COMPUTE;
                end
            end
            SEQ_COMPUTE: begin
                if (step == ROW2_STEP) begin
                    next_state = SEQ_FINISH;
                end
            end
            SEQ_FINISH: next_state = SEQ_IDLE;
            default:    next_state = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= SEQ_IDLE;
            step  <= '0;
        end else begin
            state <= next_state;
            if (state == SEQ_COMPUTE) begin
                step <= step + 1'b1;
            end else begin
                step <= '0;
            end
        end
    end

    // ==================================================
    // PE schedule and capture strobes
    // ==================================================
    always_comb begin
        pe_en    = '0;
        cap_row1 = 1'b0;
        cap_row2 = 1'b0;
        if (state == SEQ_COMPUTE) begin
            case (step)
                STEP_W'(0): pe_en.pe11 = 1'b1;
                STEP_W'(1): begin
                    pe_en.pe12 = 1'b1;
                    pe_en.pe21 = 1'b1;
                end
                // pe22 stays on into row 2, its inputs hold by then.
                ROW1_STEP: begin
                    pe_en.pe22 = 1'b1;
                    cap_row1   = 1'b1;
                end
                ROW2_STEP: begin
                    pe_en.pe22 = 1'b1;
                    cap_row2   = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // Valid pulses follow the capture edge.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            row1_valid <= 1'b0;
            row2_valid <= 1'b0;
        end else begin
            row1_valid <= cap_row1;
            row2_valid <= cap_row2;
        end
    end

    assign done = row2_valid;

endmodule

`default_nettype wire

/* hdl/mm_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module mm_lane import mm_types_pkg::*; import mm_ctrl_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   load,
    input  vec_t   a1,
    input  vec_t   a2,
    input  vec_t   b1,
    input  vec_t   b2,
    input  pe_en_t pe_en,
    input  logic   cap_row1,
    input  logic   cap_row2,
    output acc_t   row1,
    output acc_t   row2
);

    vec_t a1_q;
    vec_t a2_q;
    vec_t b1_q;
    vec_t b2_q;

    vec_t a_11_21;
    vec_t a_12_22;
    vec_t b_11_12;
    vec_t b_21_22;
    acc_t c_11_12;
    acc_t c_21_22;
    acc_t sum_12;
    acc_t sum_22;

    // Operand latch.
    always_ff @(posedge clk) begin
        if (load) begin
            a1_q <= a1;
            a2_q <= a2;
            b1_q <= b1;
            b2_q <= b2;
        end
    end

    // ==================================================
    // 2x2 grid, A runs down and B runs across.
    // ==================================================
    mac_pe pe11 (
        .clk(clk), .rst(rst), .en(pe_en.pe11),
        .a_in(a1_q), .b_in(b1_q), .c_in('0),
        .a_out(a_11_21), .b_out(b_11_12), .c_out(c_11_12)
    );

    mac_pe pe12 (
        .clk(clk), .rst(rst), .en(pe_en.pe12),
        .a_in(a2_q), .b_in(b_11_12), .c_in(c_11_12),
        .a_out(a_12_22), .b_out(), .c_out(sum_12)
    );

    mac_pe pe21 (
        .clk(clk), .rst(rst), .en(pe_en.pe21),
        .a_in(a_11_21), .b_in(b2_q), .c_in('0),
        .a_out(), .b_out(b_21_22), .c_out(c_21_22)
    );

    mac_pe pe22 (
        .clk(clk), .rst(rst), .en(pe_en.pe22),
        .a_in(a_12_22), .b_in(b_21_22), .c_in(c_21_22),
        .a_out(), .b_out(), .c_out(sum_22)
    );

    // Results hold until the next job's strobes.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            row1 <= '0;
            row2 <= '0;
        end else begin
            if (cap_row1) begin
                row1 <= sum_12;
            end
            if (cap_row2) begin
                row2 <= sum_22;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/mac_pe.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_pe import mm_types_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  vec_t a_in,
    input  vec_t b_in,
    input  acc_t c_in,
    output vec_t a_out,
    output vec_t b_out,
    output acc_t c_out
);

    acc_t dot;

    // Products are widened to the accumulator before summing.
    always_comb begin
        dot = '0;
        for (int i = 0; i < VEC_LEN; i++) begin
            dot = dot + acc_t'(a_in.e[i]) * acc_t'(b_in.e[i]);
        end
    end

    // Operands move on to the neighbours with the sum.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            a_out <= '0;
            b_out <= '0;
            c_out <= '0;
        end else if (en) begin
            a_out <= a_in;
            b_out <= b_in;
            c_out <= c_in + dot;
        end
    end

endmodule

`default_nettype wire

/* hdl/mm_ctrl_pkg.sv */
`default_nettype none

package mm_ctrl_pkg;

    // ==================================================
    // Sequencer encodings.
    // ==================================================
    typedef enum logic [1:0] {
        SEQ_IDLE    = 2'd0,
        SEQ_COMPUTE = 2'd1,
        SEQ_FINISH  = 2'd2
    } seq_state_t;

    localparam int STEP_W = 2;

    // Steps counted from the first compute cycle.
    localparam logic [STEP_W-1:0] ROW1_STEP = 2'd2;
    localparam logic [STEP_W-1:0] ROW2_STEP = 2'd3;

    // One enable per processing element of a lane.
    typedef struct packed {
        logic pe11;
        logic pe12;
        logic pe21;
        logic pe22;
    } pe_en_t;

endpackage

`default_nettype wire

/* hdl/mm_types_pkg.sv */
`default_nettype none

package mm_types_pkg;

    // ==================================================
    // Operand and accumulator sizes.
    // ==================================================
    localparam int ELEM_W  = 8;
    localparam int VEC_LEN = 4;
    localparam int ACC_W   = 32;
    localparam int LANES   = 2;

    // One unsigned matrix element.
    typedef logic [ELEM_W-1:0] elem_t;

    // Four elements, element 0 in the low byte.
    typedef struct packed {
        elem_t [VEC_LEN-1:0] e;
    } vec_t;

    // Partial and final sums.
    typedef logic [ACC_W-1:0] acc_t;

    // One vector per lane, lane 0 in the lower half.
    typedef struct packed {
        vec_t [LANES-1:0] lane;
    } operand_t;

    // One result per lane, lane 0 in the lower half.
    typedef struct packed {
        acc_t [LANES-1:0] lane;
    } result_t;

endpackage

`default_nettype wire
